// File: logic/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [3:0]  regSelT;
    typedef logic [15:0] immT;

    // Opcode field, instr[31:27]
    typedef enum logic [4:0] {
        opHalt = 5'd0,
        opNop  = 5'd1,
        opAdd  = 5'd2,
        opSub  = 5'd3,
        opAnd  = 5'd4,
        opOr   = 5'd5,
        opAddi = 5'd6,
        opAndi = 5'd7,
        opLd   = 5'd8,
        opSt   = 5'd9,
        opBeqz = 5'd10,
        opJ    = 5'd11,
        opJal  = 5'd12,
        opJr   = 5'd13,
        opSlbi = 5'd14
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluPassB = 4'd4,
        aluSlbi  = 4'd5
    } aluOpT;

    typedef struct packed {
        logic  isJAL;
        logic  regDst;
        logic  rsWrite;
        logic  regWrite;
        logic  aluSrc;
        logic  isSignExtend;
        logic  isIType1;
        logic  isBranch;
        logic  halt;
        logic  nop;
        logic  memWrite;
        logic  memRead;
        logic  memToReg;
        logic  isJR;
        logic  isSLBI;
        logic  isJump;
        aluOpT aluOp;
    } ctrlT;

    // Decode to execute bundle
    typedef struct packed {
        wordT read1Data;
        wordT read2Data;
        immT  imm;
        ctrlT ctrl;
    } decodeT;

endpackage

// File: logic/fetchStage.sv
`timescale 1ns/10ps

module fetchStage import cpuPkg::*; #(
    parameter int imemDepth = 256
) (
    input  logic clk,
    input  logic rst,
    input  logic imemLoad,
    input  wordT imemAddr,
    input  wordT imemData,
    input  wordT nextPc,
    input  logic halt,
    output wordT pc,
    output wordT pcPlus4,
    output wordT instr,
    output logic halted
);

    localparam int imemAw = $clog2(imemDepth);

    wordT imem [imemDepth];
    logic haltedReg;

    // Load address is a byte address, same as the PC
    always_ff @(posedge clk) begin
        if (rst && imemLoad) begin
            imem[imemAddr[imemAw+1:2]] <= imemData;
        end
    end

    assign instr   = imem[pc[imemAw+1:2]];
    assign pcPlus4 = pc + 32'd4;

    // Halt takes effect in the cycle the HALT word is fetched
    assign halted = haltedReg | halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            haltedReg <= 1'b0;
        end else begin
            haltedReg <= halted;
            if (!halted) begin
                pc <= nextPc;
            end
        end
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/10ps

module controlUnit import cpuPkg::*; (
    input  opcodeT opcode,
    output ctrlT   ctrl
);

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        case (opcode)
            opHalt: ctrl.halt = 1'b1;
            opNop:  ctrl.nop  = 1'b1;
            // R-type, result goes to rd
            opAdd, opSub, opAnd, opOr: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (opcode)
                    opSub:   ctrl.aluOp = aluSub;
                    opAnd:   ctrl.aluOp = aluAnd;
                    opOr:    ctrl.aluOp = aluOr;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opAddi: begin
                ctrl.regWrite     = 1'b1;
                ctrl.aluSrc       = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            opAndi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.isIType1 = 1'b1;
                ctrl.aluOp    = aluAnd;
            end
            opLd: begin
                ctrl.regWrite     = 1'b1;
                ctrl.aluSrc       = 1'b1;
                ctrl.isSignExtend = 1'b1;
                ctrl.memRead      = 1'b1;
                ctrl.memToReg     = 1'b1;
            end
            opSt: begin
                ctrl.aluSrc       = 1'b1;
                ctrl.isSignExtend = 1'b1;
                ctrl.memWrite     = 1'b1;
            end
            opBeqz: begin
                ctrl.isBranch     = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            opJ: begin
                ctrl.isJump       = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            // Link into r15
            opJal: begin
                ctrl.isJump       = 1'b1;
                ctrl.isJAL        = 1'b1;
                ctrl.regWrite     = 1'b1;
                ctrl.isSignExtend = 1'b1;
            end
            opJr: ctrl.isJR = 1'b1;
            opSlbi: begin
                ctrl.rsWrite  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.isSLBI   = 1'b1;
                ctrl.aluOp    = aluSlbi;
            end
            default: ctrl.nop = 1'b1;
        endcase
    end

endmodule

// File: logic/registerFile.sv
`timescale 1ns/10ps

module registerFile import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  regSelT read1Sel,
    input  regSelT read2Sel,
    input  regSelT writeSel,
    input  wordT   writeData,
    input  logic   write,
    output wordT   read1Data,
    output wordT   read2Data
);

    wordT regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (write) begin
            regs[writeSel] <= writeData;
        end
    end

    // No bypass, a same-cycle write shows up next cycle
    assign read1Data = regs[read1Sel];
    assign read2Data = regs[read2Sel];

endmodule

// File: logic/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  wordT   instr,
    input  wordT   pcPlus4,
    input  wordT   writebackData,
    input  logic   halted,
    output decodeT dec,
    output logic   regWriteEn,
    output regSelT regWriteSel,
    output wordT   regWriteData
);

    localparam regSelT linkReg = 4'd15;

    ctrlT   ctrl;
    regSelT rs;
    regSelT rt;
    regSelT rd;

    assign rs = instr[26:23];
    assign rt = instr[22:19];
    assign rd = instr[18:15];

    controlUnit i_controlUnit (
        .opcode (opcodeT'(instr[31:27])),
        .ctrl   (ctrl)
    );

    registerFile i_registerFile (
        .clk       (clk),
        .rst       (rst),
        .read1Sel  (rs),
        .read2Sel  (rt),
        .writeSel  (regWriteSel),
        .writeData (regWriteData),
        .write     (regWriteEn),
        .read1Data (dec.read1Data),
        .read2Data (dec.read2Data)
    );

    assign dec.imm  = instr[15:0];
    assign dec.ctrl = ctrl;

    // Destination priority: link, rs, rd, rt
    assign regWriteSel  = ctrl.isJAL ? linkReg : (ctrl.rsWrite ? rs : (ctrl.regDst ? rd : rt));
    assign regWriteData = ctrl.isJAL ? pcPlus4 : writebackData;
    assign regWriteEn   = ctrl.regWrite & ~halted & ~rst;

endmodule

// File: logic/executeStage.sv
`timescale 1ns/10ps

module executeStage import cpuPkg::*; (
    input  decodeT dec,
    input  wordT   pcPlus4,
    output wordT   aluResult,
    output wordT   storeData,
    output wordT   nextPc
);

    wordT signImm;
    wordT zeroImm;
    wordT extImm;
    wordT opA;
    wordT opB;
    wordT target;
    logic zeroExt;

    assign signImm = {{16{dec.imm[15]}}, dec.imm};
    assign zeroImm = {16'h0000, dec.imm};

    // ANDI and SLBI always take the zero-extended immediate
    assign zeroExt = dec.ctrl.isIType1 | dec.ctrl.isSLBI | ~dec.ctrl.isSignExtend;
    assign extImm  = zeroExt ? zeroImm : signImm;

    assign opA = dec.read1Data;
    assign opB = dec.ctrl.aluSrc ? extImm : dec.read2Data;

    always_comb begin
        case (dec.ctrl.aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluPassB: aluResult = opB;
            aluSlbi:  aluResult = {opA[15:0], 16'h0000} | opB;
            default:  aluResult = opA + opB;
        endcase
    end

    // Stores write rt
    assign storeData = dec.read2Data;

    // Branch and jump offsets count words
    assign target = pcPlus4 + {signImm[29:0], 2'b00};

    always_comb begin
        if (dec.ctrl.isJR) begin
            nextPc = dec.read1Data;
        end else if (dec.ctrl.isJump) begin
            nextPc = target;
        end else if (dec.ctrl.isBranch && dec.read1Data == '0) begin
            nextPc = target;
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

// File: logic/memoryStage.sv
`timescale 1ns/10ps

module memoryStage import cpuPkg::*; #(
    parameter int dmemDepth = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  decodeT dec,
    input  wordT   aluResult,
    input  wordT   storeData,
    output wordT   writebackData,
    output logic   memWriteEn,
    output wordT   memAddr,
    output wordT   memData
);

    localparam int dmemAw = $clog2(dmemDepth);

    wordT dmem [dmemDepth];
    wordT loadData;

    assign memAddr    = aluResult;
    assign memData    = storeData;
    assign memWriteEn = dec.ctrl.memWrite & ~rst;

    // Byte address in, word index used
    always_ff @(posedge clk) begin
        if (rst) begin
            dmem <= '{default: '0};
        end else if (memWriteEn) begin
            dmem[memAddr[dmemAw+1:2]] <= memData;
        end
    end

    assign loadData      = dec.ctrl.memRead ? dmem[memAddr[dmemAw+1:2]] : '0;
    assign writebackData = dec.ctrl.memToReg ? loadData : aluResult;

endmodule

// File: logic/cpuTop.sv
`timescale 1ns/10ps

module cpuTop import cpuPkg::*; #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   imemLoad,
    input  wordT   imemAddr,
    input  wordT   imemData,
    output wordT   pc,
    output logic   halted,
    output logic   regWriteEn,
    output regSelT regWriteSel,
    output wordT   regWriteData,
    output logic   memWriteEn,
    output wordT   memAddr,
    output wordT   memData
);

    wordT   instr;
    wordT   pcPlus4;
    wordT   nextPc;
    wordT   aluResult;
    wordT   storeData;
    wordT   writebackData;
    decodeT dec;

    fetchStage #(.imemDepth(imemDepth)) i_fetchStage (
        .clk      (clk),
        .rst      (rst),
        .imemLoad (imemLoad),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .nextPc   (nextPc),
        .halt     (dec.ctrl.halt),
        .pc       (pc),
        .pcPlus4  (pcPlus4),
        .instr    (instr),
        .halted   (halted)
    );

    decodeStage i_decodeStage (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .pcPlus4       (pcPlus4),
        .writebackData (writebackData),
        .halted        (halted),
        .dec           (dec),
        .regWriteEn    (regWriteEn),
        .regWriteSel   (regWriteSel),
        .regWriteData  (regWriteData)
    );

    executeStage i_executeStage (
        .dec       (dec),
        .pcPlus4   (pcPlus4),
        .aluResult (aluResult),
        .storeData (storeData),
        .nextPc    (nextPc)
    );

    memoryStage #(.dmemDepth(dmemDepth)) i_memoryStage (
        .clk           (clk),
        .rst           (rst),
        .dec           (dec),
        .aluResult     (aluResult),
        .storeData     (storeData),
        .writebackData (writebackData),
        .memWriteEn    (memWriteEn),
        .memAddr       (memAddr),
        .memData       (memData)
    );

endmodule

// File: bench/cpuTopTb.sv
`timescale 1ns/10ps

module cpuTopTb import cpuPkg::*;;

    localparam int imemDepth  = 256;
    localparam int dmemDepth  = 256;
    localparam int progLen    = 32;
    localparam int numProgs   = 3;
    localparam int cycleLimit = 2 * numProgs * progLen + 100;

    logic   clk;
    logic   rst;
    logic   imemLoad;
    wordT   imemAddr;
    wordT   imemData;
    wordT   pc;
    logic   halted;
    logic   regWriteEn;
    regSelT regWriteSel;
    wordT   regWriteData;
    logic   memWriteEn;
    wordT   memAddr;
    wordT   memData;

    // Reference model state
    wordT   mProg [imemDepth];
    wordT   mRegs [16];
    wordT   mMem [dmemDepth];
    wordT   mPc;
    logic   mHalted;
    logic   expWe;
    regSelT expSel;
    wordT   expWd;

    int progCount;
    int checks;
    int errors;
    int cycles;
    int seed;

    cpuTop #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) i_cpuTop (
        .clk          (clk),
        .rst          (rst),
        .imemLoad     (imemLoad),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .pc           (pc),
        .halted       (halted),
        .regWriteEn   (regWriteEn),
        .regWriteSel  (regWriteSel),
        .regWriteData (regWriteData),
        .memWriteEn   (memWriteEn),
        .memAddr      (memAddr),
        .memData      (memData)
    );

    always #10 clk = ~clk;

    function automatic wordT encodeInstr(opcodeT op, regSelT rs, regSelT rt, regSelT rd,
                                         logic [15:0] imm);
        // rd shares bit 15 with the immediate
        return {op, rs, rt, 19'd0} | {13'd0, rd, 15'd0} | {16'd0, imm};
    endfunction

    task automatic emit(wordT w);
        mProg[progCount] = w;
        progCount++;
    endtask

    task automatic checkValue(wordT got, wordT exp, string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic predictWrite(regSelT sel, wordT data);
        expWe  = 1'b1;
        expSel = sel;
        expWd  = data;
    endtask

    task automatic buildProgram();
        int          base;
        int          offs;
        regSelT      rs;
        regSelT      rt;
        regSelT      dst;
        logic [15:0] imm;
        progCount = 0;
        // Random constants in r1..r6 from two SLBIs each
        for (int r = 1; r <= 6; r++) begin
            emit(encodeInstr(opSlbi, regSelT'(r), 4'd0, 4'd0, 16'($urandom)));
            emit(encodeInstr(opSlbi, regSelT'(r), 4'd0, 4'd0, 16'($urandom)));
        end
        for (int k = 0; k < 8; k++) begin
            rs  = regSelT'(1 + $urandom % 6);
            rt  = regSelT'(1 + $urandom % 6);
            dst = regSelT'(7 + $urandom % 6);
            // Negative immediate tells sign from zero extension apart
            imm = 16'($urandom) | 16'h8000;
            case (k % 6)
                0: emit(encodeInstr(opAdd, rs, rt, dst, 16'h0000));
                1: emit(encodeInstr(opSub, rs, rt, dst, 16'h0000));
                2: emit(encodeInstr(opAnd, rs, rt, dst, 16'h0000));
                3: emit(encodeInstr(opOr, rs, rt, dst, 16'h0000));
                4: emit(encodeInstr(opAddi, rs, dst, 4'd0, imm));
                default: emit(encodeInstr(opAndi, rs, dst, 4'd0, imm));
            endcase
        end
        // Base address in r13 with a possibly negative offset
        base = 512 + 4 * ($urandom % 64);
        offs = -256 + 4 * ($urandom % 128);
        emit(encodeInstr(opSlbi, 4'd13, 4'd0, 4'd0, 16'h0000));
        emit(encodeInstr(opSlbi, 4'd13, 4'd0, 4'd0, 16'(base)));
        emit(encodeInstr(opSt, 4'd13, regSelT'(1 + $urandom % 6), 4'd0, 16'(offs)));
        emit(encodeInstr(opLd, 4'd13, 4'd14, 4'd0, 16'(offs)));
        // r0 is never written so this branch is taken
        emit(encodeInstr(opBeqz, 4'd0, 4'd0, 4'd0, 16'd1));
        emit(encodeInstr(opAdd, 4'd1, 4'd2, 4'd12, 16'h0000));
        emit(encodeInstr(opBeqz, 4'd1, 4'd0, 4'd0, 16'd1));
        emit(encodeInstr(opAdd, 4'd1, 4'd2, 4'd12, 16'h0000));
        // Call and return through r15 before the jump to the HALT
        emit(encodeInstr(opJal, 4'd0, 4'd0, 4'd0, 16'd1));
        emit(encodeInstr(opJ, 4'd0, 4'd0, 4'd0, 16'd1));
        emit(encodeInstr(opJr, 4'd15, 4'd0, 4'd0, 16'h0000));
        emit(encodeInstr(opHalt, 4'd0, 4'd0, 4'd0, 16'h0000));
    endtask

    // One ISA instruction per cycle against the DUT ports
    task automatic stepModel();
        wordT   instr;
        regSelT rs;
        regSelT rt;
        regSelT rd;
        wordT   a;
        wordT   b;
        wordT   sImm;
        wordT   zImm;
        wordT   target;
        wordT   addr;
        wordT   nPc;
        logic   expMe;
        instr  = mProg[mPc[9:2]];
        rs     = instr[26:23];
        rt     = instr[22:19];
        rd     = instr[18:15];
        a      = mRegs[rs];
        b      = mRegs[rt];
        sImm   = {{16{instr[15]}}, instr[15:0]};
        zImm   = {16'h0000, instr[15:0]};
        target = mPc + 4 + (sImm << 2);
        addr   = a + sImm;
        nPc    = mPc + 4;
        expWe  = 1'b0;
        expMe  = 1'b0;
        if (mHalted || opcodeT'(instr[31:27]) == opHalt) begin
            mHalted = 1'b1;
            nPc     = mPc;
        end else begin
            case (opcodeT'(instr[31:27]))
                opAdd:  predictWrite(rd, a + b);
                opSub:  predictWrite(rd, a - b);
                opAnd:  predictWrite(rd, a & b);
                opOr:   predictWrite(rd, a | b);
                opAddi: predictWrite(rt, a + sImm);
                opAndi: predictWrite(rt, a & zImm);
                opLd:   predictWrite(rt, mMem[addr[9:2]]);
                opSlbi: predictWrite(rs, (a << 16) | zImm);
                opSt:   expMe = 1'b1;
                opBeqz: nPc = (a == '0) ? target : nPc;
                opJ:    nPc = target;
                opJr:   nPc = a;
                opJal: begin
                    predictWrite(4'd15, mPc + 4);
                    nPc = target;
                end
                default: ;
            endcase
        end
        checkValue(pc, mPc, "pc");
        checkValue(wordT'(halted), wordT'(mHalted), "halted");
        checkValue(wordT'(regWriteEn), wordT'(expWe), "regWriteEn");
        if (expWe) begin
            checkValue(wordT'(regWriteSel), wordT'(expSel), "regWriteSel");
            checkValue(regWriteData, expWd, "regWriteData");
            mRegs[expSel] = expWd;
        end
        checkValue(wordT'(memWriteEn), wordT'(expMe), "memWriteEn");
        if (expMe) begin
            checkValue(memAddr, addr, "memAddr");
            checkValue(memData, b, "memData");
            mMem[addr[9:2]] = b;
        end
        mPc = nPc;
    endtask

    task automatic runProgram();
        @(negedge clk);
        rst = 1'b1;
        buildProgram();
        // A store sits at pc 0 for one cycle of reset
        imemLoad = 1'b1;
        imemAddr = '0;
        imemData = encodeInstr(opSt, 4'd1, 4'd2, 4'd0, 16'h0000);
        @(negedge clk);
        for (int i = 0; i < progLen; i++) begin
            imemLoad = 1'b1;
            imemAddr = wordT'(4 * i);
            imemData = mProg[i];
            @(negedge clk);
        end
        imemLoad = 1'b0;
        mRegs    = '{default: '0};
        mMem     = '{default: '0};
        mPc      = '0;
        mHalted  = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (!halted) @(negedge clk);
        // Halted core must stay frozen
        repeat (20) @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            checkValue(wordT'(regWriteEn), 32'd0, "regWriteEn in reset");
            checkValue(wordT'(memWriteEn), 32'd0, "memWriteEn in reset");
        end else begin
            stepModel();
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > cycleLimit) begin
                $display("Timeout: core still running after %0d cycles", cycleLimit);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    initial begin
        seed     = $urandom(32'h0b59029d);
        clk      = 1'b0;
        rst      = 1'b1;
        imemLoad = 1'b0;
        imemAddr = '0;
        imemData = '0;
        mPc      = '0;
        mHalted  = 1'b0;
        checks   = 0;
        errors   = 0;
        cycles   = 0;
        for (int p = 0; p < numProgs; p++) begin
            runProgram();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/cpuPkg.sv
logic/fetchStage.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuTop.sv
bench/cpuTopTb.sv

// File: run.sh
#!/bin/sh
# Build and run the cpuTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module cpuTopTb -Mdir "$buildDir" -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/VcpuTopTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Testbench failed" "$logFile"; then
    exit 1
fi
exit 0
